//--- tdc_echo_consts.svh
/*
 widths, subtractor latency, fifo depth and register map of the echo block
 included by the package and by every module sized from these values
*/
`ifndef TDC_ECHO_CONSTS_SVH
`define TDC_ECHO_CONSTS_SVH

// tdc datapath
`define TDC_TS_W        32
`define TDC_ANGLE_W     16
// pipeline depth of the width subtractor
`define TDC_SUB_LAT     3
// result fifo, count is wide enough for 0..depth
`define TDC_FIFO_DEPTH  8
`define TDC_CNT_W       5
// axi-lite bus
`define TDC_AXIL_AW     8
`define TDC_AXIL_DW     32
// register offsets
`define TDC_REG_CTRL    8'h00
`define TDC_REG_STATUS  8'h04
`define TDC_REG_DROP    8'h08
`define TDC_REG_RISE    8'h0C
`define TDC_REG_WIDTH   8'h10
`define TDC_REG_ANGLES  8'h14
`define TDC_REG_POP     8'h18

`endif

//--- tdc_echo_pkg.sv
/*
 record and control types shared by the echo pre-processing blocks
 modules import it in their body and use scoped names on their ports
*/
`include "tdc_echo_consts.svh"

package tdc_echo_pkg;

	// ------------------------------
	// one hit from the tdc front end
	typedef struct packed {
		logic [`TDC_TS_W-1:0]    rise;
		logic [`TDC_TS_W-1:0]    fall;
		logic [`TDC_ANGLE_W-1:0] angle1;
		logic [`TDC_ANGLE_W-1:0] angle2;
	} hit_s;

	// one echo record as stored in the result fifo
	typedef struct packed {
		logic [`TDC_TS_W-1:0]    rise;
		logic [`TDC_TS_W-1:0]    width;
		logic [`TDC_ANGLE_W-1:0] angle1;
		logic [`TDC_ANGLE_W-1:0] angle2;
	} echo_s;

	// ------------------------------
	// register block toward datapath
	typedef struct packed {
		logic enable;
		logic pop;
		logic ovf_clr;
	} echo_ctrl_s;

	// datapath toward register block
	typedef struct packed {
		logic [`TDC_CNT_W-1:0] count;
		logic                  ovf;
		logic                  drop;
	} echo_stat_s;

endpackage

//--- echo_ctrl_fsm.sv
/*
 control fsm of the echo block, takes one hit at a time through
 capture, width calculation and the write of one record into the fifo
*/
`timescale 1ns/1ps
`include "tdc_echo_consts.svh"

module echo_ctrl_fsm (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_hit_valid,
	input  tdc_echo_pkg::hit_s       i_hit,
	input  tdc_echo_pkg::echo_ctrl_s i_ctrl,
	input  logic                     i_timer_done,
	input  logic [`TDC_TS_W-1:0]     i_width,
	input  logic                     i_width_valid,
	output logic                     o_timer_start,
	output logic                     o_sub_valid,
	output logic [`TDC_TS_W-1:0]     o_sub_rise,
	output logic [`TDC_TS_W-1:0]     o_sub_fall,
	output logic                     o_wr_en,
	output tdc_echo_pkg::echo_s      o_wr_data,
	output logic                     o_drop
);
	import tdc_echo_pkg::*;

	// one-hot state bit positions
	localparam int S_READY = 1;
	localparam int S_CAL   = 2;
	localparam int S_END   = 3;
	localparam logic [3:0] ST_IDLE  = 4'b0001;
	localparam logic [3:0] ST_READY = 4'b0010;
	localparam logic [3:0] ST_CAL   = 4'b0100;
	localparam logic [3:0] ST_END   = 4'b1000;

	logic [3:0]           r_state;
	logic                 r_hit_valid;
	hit_s                 r_hit;
	hit_s                 r_cap;
	logic [`TDC_TS_W-1:0] r_width;
	logic                 r_start;
	logic                 w_accept;

	// hit only taken when idle in READY and enabled
	assign w_accept = r_hit_valid & r_state[S_READY] & i_ctrl.enable;

	// ------------------------------
	// hit strobe register
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			r_hit_valid <= 1'b0;
		else
			r_hit_valid <= i_hit_valid;
	end

	// payload follows the strobe
	always_ff @(posedge i_clk) begin
		if (i_hit_valid)
			r_hit <= i_hit;
	end

	// ------------------------------
	// state register
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state <= ST_IDLE;
			r_start <= 1'b0;
		end else begin
			r_start <= 1'b0;
			case (r_state)
				ST_IDLE: r_state <= ST_READY;
				ST_READY: begin
					if (w_accept) begin
						r_start <= 1'b1;
						r_state <= ST_CAL;
					end
				end
				// wait out the subtractor latency
				ST_CAL: begin
					if (i_timer_done)
						r_state <= ST_END;
				end
				ST_END: r_state <= ST_READY;
				default: r_state <= ST_IDLE;
			endcase
		end
	end

	// captured hit and result width
	always_ff @(posedge i_clk) begin
		if (w_accept)
			r_cap <= r_hit;
		if (i_width_valid)
			r_width <= i_width;
	end

	// ------------------------------
	// outputs
	assign o_timer_start = r_start;
	assign o_sub_valid   = r_start;
	assign o_sub_rise    = r_cap.rise;
	assign o_sub_fall    = r_cap.fall;
	assign o_wr_en       = r_state[S_END];
	assign o_wr_data     = '{rise: r_cap.rise, width: r_width,
		angle1: r_cap.angle1, angle2: r_cap.angle2};
	// busy or disabled, the hit is lost
	assign o_drop        = r_hit_valid & ~(r_state[S_READY] & i_ctrl.enable);

	a_state_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$onehot(r_state));
	a_width_in_cal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_width_valid |-> r_state[S_CAL]);
	a_wr_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_wr_en |=> !o_wr_en);

endmodule

//--- settle_timer.sv
/*
 down-counter covering the subtractor latency, done pulses once per start
*/
`timescale 1ns/1ps
`include "tdc_echo_consts.svh"

module settle_timer (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_start,
	output logic o_done
);
	localparam int CNT_W = $clog2(`TDC_SUB_LAT + 1);

	logic [CNT_W-1:0] r_cnt;
	logic             r_done;

	// load on start, count to zero, flag the last step
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_cnt  <= '0;
			r_done <= 1'b0;
		end else begin
			r_done <= (r_cnt == CNT_W'(1));
			if (i_start)
				r_cnt <= CNT_W'(`TDC_SUB_LAT);
			else if (r_cnt != '0)
				r_cnt <= r_cnt - 1'b1;
		end
	end

	assign o_done = r_done;

	a_no_restart: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_start |-> (r_cnt == '0));

endmodule

//--- pulse_width_calc.sv
/*
 three-stage split-borrow subtractor, width = fall - rise modulo 2^32
 fully pipelined, a new operand pair may enter every cycle
*/
`timescale 1ns/1ps
`include "tdc_echo_consts.svh"

module pulse_width_calc (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_valid,
	input  logic [`TDC_TS_W-1:0] i_rise,
	input  logic [`TDC_TS_W-1:0] i_fall,
	output logic                 o_valid,
	output logic [`TDC_TS_W-1:0] o_width
);
	localparam int W = `TDC_TS_W;
	localparam int H = W / 2;

	logic         r_v1, r_v2, r_v3;
	logic [W-1:0] r_rise1, r_fall1;
	logic [H-1:0] r_lo2, r_rise_hi2, r_fall_hi2;
	logic         r_borrow2;
	logic [W-1:0] r_width3;

	// valid shift chain
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_v1 <= 1'b0;
			r_v2 <= 1'b0;
			r_v3 <= 1'b0;
		end else begin
			r_v1 <= i_valid;
			r_v2 <= r_v1;
			r_v3 <= r_v2;
		end
	end

	always_ff @(posedge i_clk) begin
		// stage 1 operands
		r_rise1    <= i_rise;
		r_fall1    <= i_fall;
		// stage 2 low half, top bit is the borrow
		{r_borrow2, r_lo2} <= {1'b0, r_fall1[H-1:0]} - {1'b0, r_rise1[H-1:0]};
		r_rise_hi2 <= r_rise1[W-1:H];
		r_fall_hi2 <= r_fall1[W-1:H];
		// stage 3 high half, wraps naturally
		r_width3   <= {r_fall_hi2 - r_rise_hi2 - H'(r_borrow2), r_lo2};
	end

	assign o_valid = r_v3;
	assign o_width = r_width3;

endmodule

//--- echo_result_fifo.sv
/*
 circular buffer of echo records with fill count and sticky overflow
 head record is always visible, pop removes it
*/
`timescale 1ns/1ps
`include "tdc_echo_consts.svh"

module echo_result_fifo (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_wr_en,
	input  tdc_echo_pkg::echo_s   i_wr_data,
	input  logic                  i_pop,
	input  logic                  i_ovf_clr,
	output tdc_echo_pkg::echo_s   o_head,
	output logic [`TDC_CNT_W-1:0] o_count,
	output logic                  o_ovf
);
	import tdc_echo_pkg::*;

	localparam int DEPTH = `TDC_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = `TDC_CNT_W;

	echo_s            r_mem [DEPTH];
	logic [PTR_W-1:0] r_wr_ptr, r_rd_ptr;
	logic [CNT_W-1:0] r_count;
	logic             r_ovf;
	logic             w_full, w_push, w_pop;

	// wrap for any depth, not only powers of two
	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		if (p == PTR_W'(DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	assign w_full = (r_count == CNT_W'(DEPTH));
	assign w_push = i_wr_en & ~w_full;
	// pop on empty is ignored
	assign w_pop  = i_pop & (r_count != '0);

	// ------------------------------
	// storage
	always_ff @(posedge i_clk) begin
		if (w_push)
			r_mem[r_wr_ptr] <= i_wr_data;
	end

	// pointers, count and overflow
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
			r_count  <= '0;
			r_ovf    <= 1'b0;
		end else begin
			if (w_push)
				r_wr_ptr <= ptr_next(r_wr_ptr);
			if (w_pop)
				r_rd_ptr <= ptr_next(r_rd_ptr);
			case ({w_push, w_pop})
				2'b10: r_count <= r_count + 1'b1;
				2'b01: r_count <= r_count - 1'b1;
				default: r_count <= r_count;
			endcase
			// a write into a full fifo wins over the clear
			if (i_wr_en && w_full)
				r_ovf <= 1'b1;
			else if (i_ovf_clr)
				r_ovf <= 1'b0;
		end
	end

	assign o_head  = r_mem[r_rd_ptr];
	assign o_count = r_count;
	assign o_ovf   = r_ovf;

	a_count_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		r_count <= CNT_W'(DEPTH));

endmodule

//--- echo_axil_regs.sv
/*
 axi4-lite register slave: enable, status, drop counter and fifo readout
 one write and one read handshake at a time, responses held until taken
*/
`timescale 1ns/1ps
`include "tdc_echo_consts.svh"

module echo_axil_regs (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic [`TDC_AXIL_AW-1:0]  i_s_axil_awaddr,
	input  logic                     i_s_axil_awvalid,
	output logic                     o_s_axil_awready,
	input  logic [`TDC_AXIL_DW-1:0]  i_s_axil_wdata,
	input  logic                     i_s_axil_wvalid,
	output logic                     o_s_axil_wready,
	output logic                     o_s_axil_bvalid,
	input  logic                     i_s_axil_bready,
	input  logic [`TDC_AXIL_AW-1:0]  i_s_axil_araddr,
	input  logic                     i_s_axil_arvalid,
	output logic                     o_s_axil_arready,
	output logic [`TDC_AXIL_DW-1:0]  o_s_axil_rdata,
	output logic                     o_s_axil_rvalid,
	input  logic                     i_s_axil_rready,
	input  tdc_echo_pkg::echo_stat_s i_stat,
	input  tdc_echo_pkg::echo_s      i_head,
	output tdc_echo_pkg::echo_ctrl_s o_ctrl
);
	import tdc_echo_pkg::*;

	localparam int DW    = `TDC_AXIL_DW;
	localparam int CNT_W = `TDC_CNT_W;

	logic          r_wr_rdy, r_bvalid;
	logic          r_rd_rdy, r_rvalid;
	logic [DW-1:0] r_rdata;
	logic          r_enable, r_pop, r_ovf_clr;
	logic [DW-1:0] r_drop_cnt;
	logic          w_wr_fire, w_rd_fire, w_drop_clr;
	logic [DW-1:0] w_rd_mux;

	assign w_wr_fire  = r_wr_rdy & i_s_axil_awvalid & i_s_axil_wvalid;
	assign w_rd_fire  = r_rd_rdy & i_s_axil_arvalid;
	// reading DROP clears it
	assign w_drop_clr = w_rd_fire & (i_s_axil_araddr == `TDC_REG_DROP);

	// ------------------------------
	// write channel, aw and w taken together
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_wr_rdy <= 1'b0;
			r_bvalid <= 1'b0;
		end else begin
			r_wr_rdy <= i_s_axil_awvalid & i_s_axil_wvalid & ~r_wr_rdy & ~r_bvalid;
			if (w_wr_fire)
				r_bvalid <= 1'b1;
			else if (i_s_axil_bready)
				r_bvalid <= 1'b0;
		end
	end

	// control bits and one-cycle pulses
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_enable  <= 1'b0;
			r_pop     <= 1'b0;
			r_ovf_clr <= 1'b0;
		end else begin
			r_pop     <= w_wr_fire & (i_s_axil_awaddr == `TDC_REG_POP);
			r_ovf_clr <= w_wr_fire & (i_s_axil_awaddr == `TDC_REG_STATUS) & i_s_axil_wdata[8];
			if (w_wr_fire && i_s_axil_awaddr == `TDC_REG_CTRL)
				r_enable <= i_s_axil_wdata[0];
		end
	end

	// ------------------------------
	// saturating drop counter
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			r_drop_cnt <= '0;
		else if (w_drop_clr)
			// a drop in the read cycle is not lost
			r_drop_cnt <= DW'(i_stat.drop);
		else if (i_stat.drop && r_drop_cnt != '1)
			r_drop_cnt <= r_drop_cnt + 1'b1;
	end

	// ------------------------------
	// read decode, unmapped reads as zero
	always_comb begin
		w_rd_mux = '0;
		case (i_s_axil_araddr)
			`TDC_REG_CTRL:   w_rd_mux = DW'(r_enable);
			`TDC_REG_STATUS: begin
				w_rd_mux[CNT_W-1:0] = i_stat.count;
				w_rd_mux[8]         = i_stat.ovf;
			end
			`TDC_REG_DROP:   w_rd_mux = r_drop_cnt;
			`TDC_REG_RISE:   w_rd_mux = i_head.rise;
			`TDC_REG_WIDTH:  w_rd_mux = i_head.width;
			// angle1 in the upper half
			`TDC_REG_ANGLES: w_rd_mux = {i_head.angle1, i_head.angle2};
			default:         w_rd_mux = '0;
		endcase
	end

	// read channel
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_rd_rdy <= 1'b0;
			r_rvalid <= 1'b0;
		end else begin
			r_rd_rdy <= i_s_axil_arvalid & ~r_rd_rdy & ~r_rvalid;
			if (w_rd_fire)
				r_rvalid <= 1'b1;
			else if (i_s_axil_rready)
				r_rvalid <= 1'b0;
		end
	end

	always_ff @(posedge i_clk) begin
		if (w_rd_fire)
			r_rdata <= w_rd_mux;
	end

	// ------------------------------
	// outputs
	assign o_s_axil_awready = r_wr_rdy;
	assign o_s_axil_wready  = r_wr_rdy;
	assign o_s_axil_bvalid  = r_bvalid;
	assign o_s_axil_arready = r_rd_rdy;
	assign o_s_axil_rvalid  = r_rvalid;
	assign o_s_axil_rdata   = r_rdata;
	assign o_ctrl           = '{enable: r_enable, pop: r_pop, ovf_clr: r_ovf_clr};

endmodule

//--- tdc_echo_top.sv
/*
 top of the echo pre-processing block, hits in and records out over axi-lite
*/
`timescale 1ns/1ps
`include "tdc_echo_consts.svh"

module tdc_echo_top (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_hit_valid,
	input  tdc_echo_pkg::hit_s      i_hit,
	input  logic [`TDC_AXIL_AW-1:0] i_s_axil_awaddr,
	input  logic                    i_s_axil_awvalid,
	output logic                    o_s_axil_awready,
	input  logic [`TDC_AXIL_DW-1:0] i_s_axil_wdata,
	input  logic                    i_s_axil_wvalid,
	output logic                    o_s_axil_wready,
	output logic                    o_s_axil_bvalid,
	input  logic                    i_s_axil_bready,
	input  logic [`TDC_AXIL_AW-1:0] i_s_axil_araddr,
	input  logic                    i_s_axil_arvalid,
	output logic                    o_s_axil_arready,
	output logic [`TDC_AXIL_DW-1:0] o_s_axil_rdata,
	output logic                    o_s_axil_rvalid,
	input  logic                    i_s_axil_rready,
	output logic                    o_irq
);
	import tdc_echo_pkg::*;

	echo_ctrl_s            w_ctrl;
	echo_stat_s            w_stat;
	echo_s                 w_wr_data, w_head;
	logic                  w_wr_en, w_drop, w_ovf;
	logic                  w_timer_start, w_timer_done;
	logic                  w_sub_valid, w_width_valid;
	logic [`TDC_TS_W-1:0]  w_sub_rise, w_sub_fall, w_width;
	logic [`TDC_CNT_W-1:0] w_count;

	// status bundle toward the registers
	assign w_stat = '{count: w_count, ovf: w_ovf, drop: w_drop};
	// interrupt while records wait
	assign o_irq  = (w_count != '0);

	// ------------------------------
	echo_ctrl_fsm u_fsm (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_hit_valid(i_hit_valid), .i_hit(i_hit), .i_ctrl(w_ctrl),
		.i_timer_done(w_timer_done), .i_width(w_width), .i_width_valid(w_width_valid),
		.o_timer_start(w_timer_start), .o_sub_valid(w_sub_valid),
		.o_sub_rise(w_sub_rise), .o_sub_fall(w_sub_fall),
		.o_wr_en(w_wr_en), .o_wr_data(w_wr_data), .o_drop(w_drop)
	);

	settle_timer u_timer (
		.i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(w_timer_start), .o_done(w_timer_done)
	);

	pulse_width_calc u_sub (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_valid(w_sub_valid), .i_rise(w_sub_rise), .i_fall(w_sub_fall),
		.o_valid(w_width_valid), .o_width(w_width)
	);

	echo_result_fifo u_fifo (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_wr_en(w_wr_en), .i_wr_data(w_wr_data),
		.i_pop(w_ctrl.pop), .i_ovf_clr(w_ctrl.ovf_clr),
		.o_head(w_head), .o_count(w_count), .o_ovf(w_ovf)
	);

	echo_axil_regs u_regs (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_s_axil_awaddr(i_s_axil_awaddr), .i_s_axil_awvalid(i_s_axil_awvalid),
		.o_s_axil_awready(o_s_axil_awready),
		.i_s_axil_wdata(i_s_axil_wdata), .i_s_axil_wvalid(i_s_axil_wvalid),
		.o_s_axil_wready(o_s_axil_wready),
		.o_s_axil_bvalid(o_s_axil_bvalid), .i_s_axil_bready(i_s_axil_bready),
		.i_s_axil_araddr(i_s_axil_araddr), .i_s_axil_arvalid(i_s_axil_arvalid),
		.o_s_axil_arready(o_s_axil_arready),
		.o_s_axil_rdata(o_s_axil_rdata), .o_s_axil_rvalid(o_s_axil_rvalid),
		.i_s_axil_rready(i_s_axil_rready),
		.i_stat(w_stat), .i_head(w_head), .o_ctrl(w_ctrl)
	);

endmodule

//--- tb_tdc_echo.sv
/*
 self-checking testbench of the echo block
 drives hits and reads the records back over axi-lite against a reference model
*/
`timescale 1ns/1ps
`include "tdc_echo_consts.svh"

module tb_tdc_echo;
	import tdc_echo_pkg::*;

	// 1 disabled + 20 streamed + 2 back to back + 10 overflow
	localparam int N_HITS  = 33;
	localparam int HIT_GAP = 20;
	localparam int LIMIT   = N_HITS * (`TDC_SUB_LAT + 20) + 2000;

	logic                    clk;
	logic                    rst_n;
	logic                    hit_valid;
	hit_s                    hit;
	logic [`TDC_AXIL_AW-1:0] awaddr;
	logic [`TDC_AXIL_AW-1:0] araddr;
	logic [`TDC_AXIL_DW-1:0] wdata;
	logic [`TDC_AXIL_DW-1:0] rdata;
	logic                    awvalid, awready, wvalid, wready, bvalid, bready;
	logic                    arvalid, arready, rvalid, rready;
	logic                    irq;

	logic [31:0] lfsr;
	int          cycle_cnt;
	int          wrap_cnt;
	echo_s       exp_q[$];

	tdc_echo_top UUT (
		.i_clk(clk), .i_rst_n(rst_n), .i_hit_valid(hit_valid), .i_hit(hit),
		.i_s_axil_awaddr(awaddr), .i_s_axil_awvalid(awvalid), .o_s_axil_awready(awready),
		.i_s_axil_wdata(wdata), .i_s_axil_wvalid(wvalid), .o_s_axil_wready(wready),
		.o_s_axil_bvalid(bvalid), .i_s_axil_bready(bready),
		.i_s_axil_araddr(araddr), .i_s_axil_arvalid(arvalid), .o_s_axil_arready(arready),
		.o_s_axil_rdata(rdata), .o_s_axil_rvalid(rvalid), .i_s_axil_rready(rready),
		.o_irq(irq)
	);

	// ------------------------------
	// 100 MHz clock and run limit
	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= LIMIT) begin
			$display("TEST FAILED");
			$fatal(1, "timeout waiting for test end");
		end
	end

	// galois lfsr with taps of x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic lsb;
		lsb = s[0];
		s   = s >> 1;
		if (lsb)
			s = s ^ 32'h80200003;
		return s;
	endfunction

	// one lfsr step per bit
	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic make_hit(output hit_s h);
		logic [31:0] v;
		draw_bits(32, v);
		h.rise = v;
		draw_bits(32, v);
		h.fall = v;
		draw_bits(16, v);
		h.angle1 = v[15:0];
		draw_bits(16, v);
		h.angle2 = v[15:0];
	endtask

	// expected record with width fall - rise modulo 2^32
	function automatic echo_s ref_echo(input hit_s h);
		echo_s e;
		e.rise   = h.rise;
		e.width  = h.fall - h.rise;
		e.angle1 = h.angle1;
		e.angle2 = h.angle2;
		return e;
	endfunction

	// ------------------------------
	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [`TDC_AXIL_DW-1:0] exp,
		input logic [`TDC_AXIL_DW-1:0] act);
		if (act !== exp)
			report_failure($sformatf("CHECK FAILED %s exp %h act %h", name, exp, act));
	endtask

	task automatic check_echo(input echo_s exp, input echo_s act);
		if (act.rise !== exp.rise)
			report_failure($sformatf("CHECK FAILED RISE exp %h act %h", exp.rise, act.rise));
		if (act.width !== exp.width)
			report_failure($sformatf("CHECK FAILED WIDTH exp %h act %h", exp.width, act.width));
		if ({act.angle1, act.angle2} !== {exp.angle1, exp.angle2})
			report_failure($sformatf("CHECK FAILED ANGLES exp %h act %h",
				{exp.angle1, exp.angle2}, {act.angle1, act.angle2}));
	endtask

	// ------------------------------
	// axi-lite master sampling readies at the falling edge
	task automatic axil_write(input logic [`TDC_AXIL_AW-1:0] addr,
		input logic [`TDC_AXIL_DW-1:0] data);
		@(posedge clk);
		#1;
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		@(negedge clk);
		while (!awready)
			@(negedge clk);
		// aw and w are accepted in the same cycle
		check_word("wready", 32'h1, wready);
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		wvalid  = 1'b0;
		bready  = 1'b1;
		@(negedge clk);
		while (!bvalid)
			@(negedge clk);
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	task automatic axil_read(input logic [`TDC_AXIL_AW-1:0] addr,
		output logic [`TDC_AXIL_DW-1:0] data);
		@(posedge clk);
		#1;
		araddr  = addr;
		arvalid = 1'b1;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		@(posedge clk);
		#1;
		arvalid = 1'b0;
		rready  = 1'b1;
		@(negedge clk);
		while (!rvalid)
			@(negedge clk);
		data = rdata;
		@(posedge clk);
		#1;
		rready = 1'b0;
	endtask

	// read the head record then pop it
	task automatic read_echo(output echo_s rec);
		logic [`TDC_AXIL_DW-1:0] w;
		axil_read(`TDC_REG_RISE, w);
		rec.rise = w;
		axil_read(`TDC_REG_WIDTH, w);
		rec.width = w;
		axil_read(`TDC_REG_ANGLES, w);
		rec.angle1 = w[31:16];
		rec.angle2 = w[15:0];
		axil_write(`TDC_REG_POP, '0);
	endtask

	task automatic compare_next(input echo_s rec);
		echo_s exp;
		if (exp_q.size() == 0)
			report_failure("a record was read while no record was expected");
		exp = exp_q.pop_front();
		check_echo(exp, rec);
	endtask

	task automatic wait_irq();
		@(negedge clk);
		while (!irq)
			@(negedge clk);
	endtask

	task automatic send_hit(input hit_s h);
		@(posedge clk);
		#1;
		hit       = h;
		hit_valid = 1'b1;
		@(posedge clk);
		#1;
		hit_valid = 1'b0;
	endtask

	// ------------------------------
	initial begin
		hit_s                    h;
		hit_s                    h2;
		echo_s                   rec;
		logic [`TDC_AXIL_DW-1:0] word;
		rst_n     = 1'b0;
		hit_valid = 1'b0;
		hit       = '0;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		cycle_cnt = 0;
		wrap_cnt  = 0;
		lfsr      = 32'h01595657;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// disabled block only counts the hit
		make_hit(h);
		send_hit(h);
		// long enough for a record to land
		repeat (HIT_GAP - 2) @(posedge clk);
		axil_read(`TDC_REG_STATUS, word);
		check_word("STATUS", 32'h0, word);
		axil_read(`TDC_REG_DROP, word);
		check_word("DROP", 32'h1, word);
		axil_read(`TDC_REG_DROP, word);
		check_word("DROP", 32'h0, word);

		// reader drains while streamed hits keep coming
		axil_write(`TDC_REG_CTRL, 32'h1);
		fork
			begin
				for (int i = 0; i < 20; i++) begin
					make_hit(h);
					// hits whose width has to wrap
					if (h.fall < h.rise)
						wrap_cnt++;
					exp_q.push_back(ref_echo(h));
					send_hit(h);
					repeat (HIT_GAP - 2) @(posedge clk);
				end
			end
			begin
				for (int n = 0; n < 20; n++) begin
					wait_irq();
					read_echo(rec);
					compare_next(rec);
				end
			end
		join
		@(negedge clk);
		check_word("o_irq", 32'h0, irq);

		// second hit lands while the fsm is busy
		make_hit(h);
		make_hit(h2);
		exp_q.push_back(ref_echo(h));
		@(posedge clk);
		#1;
		hit       = h;
		hit_valid = 1'b1;
		@(posedge clk);
		#1;
		hit = h2;
		@(posedge clk);
		#1;
		hit_valid = 1'b0;
		wait_irq();
		read_echo(rec);
		compare_next(rec);
		axil_read(`TDC_REG_DROP, word);
		check_word("DROP", 32'h1, word);

		// ------------------------------
		// overrun keeps only the first 8
		for (int i = 0; i < 10; i++) begin
			make_hit(h);
			exp_q.push_back(ref_echo(h));
			send_hit(h);
			repeat (HIT_GAP - 2) @(posedge clk);
		end
		axil_read(`TDC_REG_STATUS, word);
		check_word("STATUS", 32'h108, word);
		axil_write(`TDC_REG_STATUS, 32'h100);
		axil_read(`TDC_REG_STATUS, word);
		check_word("STATUS", 32'h008, word);
		for (int n = 0; n < 8; n++) begin
			check_word("o_irq", 32'h1, irq);
			read_echo(rec);
			compare_next(rec);
		end
		@(negedge clk);
		check_word("o_irq", 32'h0, irq);
		// the two late records were thrown away
		check_word("lost records", 32'h2, exp_q.size());
		exp_q.delete();

		if (wrap_cnt > 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("no hit with a wrapping width was generated");
			$display("TEST FAILED");
			$fatal(1, "final checks did not hold");
		end
	end

endmodule

//--- tdc_echo_top.f
+incdir+.
tdc_echo_pkg.sv
echo_ctrl_fsm.sv
settle_timer.sv
pulse_width_calc.sv
echo_result_fifo.sv
echo_axil_regs.sv
tdc_echo_top.sv
tb_tdc_echo.sv

//--- Bender.yml
package:
  name: tdc_echo

export_include_dirs:
  - .

sources:
  - tdc_echo_pkg.sv
  - echo_ctrl_fsm.sv
  - settle_timer.sv
  - pulse_width_calc.sv
  - echo_result_fifo.sv
  - echo_axil_regs.sv
  - tdc_echo_top.sv
  - target: test
    files:
      - tb_tdc_echo.sv
